//--- hdl/paletteDefs.sv
// Shared palette constants, bus address map and entry layout; imported by every palette module
`default_nettype none

package paletteDefs;

	// ======================================================================
	// Widths
	// ======================================================================

	// Default index width per bank, 4096 entries as on the board
	localparam int PAL_INDEX_W = 12;
	// One output colour channel
	localparam int COLOR_W = 8;

	// ======================================================================
	// Bus address map
	// ======================================================================

	// Entry i sits at byte address 4*i, control register above the palette
	localparam logic [15:0] CTRL_ADDR = 16'h4000;
	// Control register fields
	localparam int CTRL_BANK_BIT = 0;
	localparam int CTRL_SHADOW_BIT = 1;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ======================================================================
	// Palette entry
	// ======================================================================

	// Raw view for the CPU side, field view for the colour path
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			// Common darkening bit, subtracted from all channels
			logic dark;
			// Shared low bits, one per channel
			logic rLsb;
			logic gLsb;
			logic bLsb;
			logic [3:0] red;
			logic [3:0] green;
			logic [3:0] blue;
		} color;
	} paletteEntry_u;

endpackage

`default_nettype wire

//--- hdl/paletteBus.sv
// AXI4-Lite slave for the host CPU; decodes palette and control addresses and drives the RAM port
`timescale 1ns/1ps
`default_nettype none

module paletteBus import paletteDefs::*; #(
	parameter int INDEX_W = PAL_INDEX_W
) (
	input wire logic CLK_24M,
	input wire logic nRESET,
	// Write address and data
	input wire logic [15:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [31:0] wdata,
	input wire logic [3:0] wstrb,
	input wire logic wvalid,
	output logic wready,
	// Write response
	output logic [1:0] bresp,
	output logic bvalid,
	input wire logic bready,
	// Read address and data
	input wire logic [15:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire logic rready,
	// Palette RAM CPU port
	output logic [INDEX_W-1:0] cpuIndex,
	output paletteEntry_u cpuWrData,
	output logic [1:0] cpuByteEn,
	output logic cpuWrite,
	output logic cpuRead,
	input wire paletteEntry_u cpuRdData,
	// Control register outputs
	output logic bank,
	output logic shadow
);

	logic wrAccept;
	logic wrAcceptNext;
	logic wrFire;
	logic arreadyNext;
	logic rdFire;
	logic awPal;
	logic awCtrl;
	logic arPal;
	logic arCtrl;
	logic rdStage;
	logic rdPal;
	logic rdCtrl;
	logic [1:0] ctrlReg;

	// ======================================================================
	// Address decode
	// ======================================================================

	// Palette window is 4 bytes per entry from address zero
	function automatic logic isPalette(input logic [15:0] addr);
		isPalette = (addr >> (INDEX_W + 2)) == 16'd0;
	endfunction

	// Word match, byte lanes ignored
	function automatic logic isCtrl(input logic [15:0] addr);
		isCtrl = addr[15:2] == CTRL_ADDR[15:2];
	endfunction

	assign awPal = isPalette(awaddr);
	assign awCtrl = isCtrl(awaddr);
	assign arPal = isPalette(araddr);
	assign arCtrl = isCtrl(araddr);

	// ======================================================================
	// Write channel
	// ======================================================================

	// One-cycle ready pulse, only with both valids and no response pending
	assign wrAcceptNext = ~wrAccept & awvalid & wvalid & ~bvalid;
	assign awready = wrAccept;
	assign wready = wrAccept;
	assign wrFire = wrAccept & awvalid & wvalid;

	always_ff @(posedge CLK_24M or negedge nRESET) begin
		if (!nRESET) begin
			wrAccept <= 1'b0;
			bvalid <= 1'b0;
			ctrlReg <= '0;
		end else begin
			wrAccept <= wrAcceptNext;
			// Response follows the accepting cycle, held until taken
			if (wrFire) begin
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			// Only the low byte lane reaches the control bits
			if (wrFire && awCtrl && wstrb[0]) begin
				ctrlReg <= wdata[1:0];
			end
		end
	end

	always_ff @(posedge CLK_24M) begin
		if (wrFire) begin
			bresp <= (awPal || awCtrl) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ======================================================================
	// Read channel
	// ======================================================================

	// Writes win; one read in flight until its data is taken
	assign arreadyNext = ~arready & arvalid & ~rdStage & ~rvalid & ~wrAcceptNext;
	assign rdFire = arready & arvalid;

	always_ff @(posedge CLK_24M or negedge nRESET) begin
		if (!nRESET) begin
			arready <= 1'b0;
			rdStage <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arreadyNext;
			// RAM cycle between accept and data
			rdStage <= rdFire;
			if (rdStage) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Read source chosen at accept, data captured a cycle later
	always_ff @(posedge CLK_24M) begin
		if (rdFire) begin
			rdPal <= arPal;
			rdCtrl <= arCtrl;
		end
		if (rdStage) begin
			if (rdPal) begin
				rdata <= {16'h0000, cpuRdData.raw};
			end else if (rdCtrl) begin
				rdata <= {30'd0, ctrlReg};
			end else begin
				rdata <= '0;
			end
			rresp <= (rdPal || rdCtrl) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ======================================================================
	// RAM port and control outputs
	// ======================================================================

	// Write and read never fire together, so one index mux suffices
	assign cpuIndex = wrFire ? awaddr[INDEX_W+1:2] : araddr[INDEX_W+1:2];
	assign cpuWrData.raw = wdata[15:0];
	assign cpuByteEn = wstrb[1:0];
	assign cpuWrite = wrFire & awPal;
	assign cpuRead = rdFire & arPal;

	assign bank = ctrlReg[CTRL_BANK_BIT];
	assign shadow = ctrlReg[CTRL_SHADOW_BIT];

endmodule

`default_nettype wire

//--- hdl/paletteRam.sv
// Two-bank palette memory; byte-enabled CPU port and a read-only pixel port, both registered
`timescale 1ns/1ps
`default_nettype none

module paletteRam import paletteDefs::*; #(
	parameter int INDEX_W = PAL_INDEX_W
) (
	input wire logic CLK_24M,
	// Bank select shared by both ports
	input wire logic bank,
	// CPU port
	input wire logic [INDEX_W-1:0] cpuIndex,
	input wire paletteEntry_u cpuWrData,
	input wire logic [1:0] cpuByteEn,
	input wire logic cpuWrite,
	input wire logic cpuRead,
	output paletteEntry_u cpuRdData,
	// Pixel port
	input wire logic [INDEX_W-1:0] pixelIndex,
	output paletteEntry_u pixelEntry
);

	localparam int DEPTH = 2 ** (INDEX_W + 1);

	logic [15:0] mem [0:DEPTH-1];
	logic [INDEX_W:0] cpuAddr;
	logic [INDEX_W:0] pixelAddr;

	// Bank bit sits above the index
	assign cpuAddr = {bank, cpuIndex};
	assign pixelAddr = {bank, pixelIndex};

	// ======================================================================
	// CPU port
	// ======================================================================

	always_ff @(posedge CLK_24M) begin
		if (cpuWrite) begin
			// Low byte holds green and blue
			if (cpuByteEn[0]) begin
				mem[cpuAddr][7:0] <= cpuWrData.raw[7:0];
			end
			// High byte holds dark, shared lsbs and red
			if (cpuByteEn[1]) begin
				mem[cpuAddr][15:8] <= cpuWrData.raw[15:8];
			end
		end
		// Data held until the next read
		if (cpuRead) begin
			cpuRdData.raw <= mem[cpuAddr];
		end
	end

	// ======================================================================
	// Pixel port
	// ======================================================================

	// Read every cycle, a same-cycle CPU write shows up one pixel later
	always_ff @(posedge CLK_24M) begin
		pixelEntry.raw <= mem[pixelAddr];
	end

endmodule

`default_nettype wire

//--- hdl/colorConvert.sv
// Colour output path; turns palette entries from the RAM into shaded 24-bit RGB two cycles on
`timescale 1ns/1ps
`default_nettype none

module colorConvert import paletteDefs::*; #(
	parameter int INDEX_W = PAL_INDEX_W
) (
	input wire logic CLK_24M,
	input wire logic nRESET,
	input wire logic pixelValid,
	// Entry read by the RAM one cycle after pixelValid
	input wire paletteEntry_u pixelEntry,
	input wire logic shadow,
	output logic [COLOR_W-1:0] red,
	output logic [COLOR_W-1:0] green,
	output logic [COLOR_W-1:0] blue,
	output logic rgbValid
);

	logic validS1;

	// Palette depth beyond the board's index width is not addressable
	if (INDEX_W < 1 || INDEX_W > PAL_INDEX_W) begin : gIndexCheck
		$error("colorConvert: INDEX_W out of range");
	end

	// ======================================================================
	// Channel conversion
	// ======================================================================

	// 4-bit field plus shared lsb to 6 bits, darken, widen to 8, shade
	function automatic logic [COLOR_W-1:0] convert(
		input logic [3:0] field,
		input logic lsb,
		input logic dark,
		input logic half
	);
		logic [6:0] level;
		logic [COLOR_W-1:0] wide;
		// Top bit of the field fills the lowest position
		level = {1'b0, field, lsb, field[3]} - {6'd0, dark};
		// Borrow out means the dark step went below black
		if (level[6]) begin
			wide = '0;
		end else begin
			wide = {level[5:0], level[4:3]};
		end
		// Shadow halves the intensity
		convert = half ? {1'b0, wide[COLOR_W-1:1]} : wide;
	endfunction

	// ======================================================================
	// Pipeline
	// ======================================================================

	// Stage one is the RAM read, only the valid travels here
	always_ff @(posedge CLK_24M or negedge nRESET) begin
		if (!nRESET) begin
			validS1 <= 1'b0;
			rgbValid <= 1'b0;
		end else begin
			validS1 <= pixelValid;
			rgbValid <= validS1;
		end
	end

	// Stage two, shadow taken in the pixel's second cycle
	always_ff @(posedge CLK_24M) begin
		red <= convert(pixelEntry.color.red, pixelEntry.color.rLsb,
			pixelEntry.color.dark, shadow);
		green <= convert(pixelEntry.color.green, pixelEntry.color.gLsb,
			pixelEntry.color.dark, shadow);
		blue <= convert(pixelEntry.color.blue, pixelEntry.color.bLsb,
			pixelEntry.color.dark, shadow);
	end

endmodule

`default_nettype wire

//--- hdl/neoPaletteTop.sv
// Top level of the palette block; joins the AXI4-Lite slave, the palette RAM and the RGB converter
`timescale 1ns/1ps
`default_nettype none

module neoPaletteTop import paletteDefs::*; #(
	parameter int INDEX_W = PAL_INDEX_W
) (
	input wire logic CLK_24M,
	input wire logic nRESET,
	// AXI4-Lite write side
	input wire logic [15:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [31:0] wdata,
	input wire logic [3:0] wstrb,
	input wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire logic bready,
	// AXI4-Lite read side
	input wire logic [15:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire logic rready,
	// Pixel stream, no back-pressure
	input wire logic [INDEX_W-1:0] pixelIndex,
	input wire logic pixelValid,
	output logic [COLOR_W-1:0] red,
	output logic [COLOR_W-1:0] green,
	output logic [COLOR_W-1:0] blue,
	output logic rgbValid
);

	logic [INDEX_W-1:0] cpuIndex;
	paletteEntry_u cpuWrData;
	logic [1:0] cpuByteEn;
	logic cpuWrite;
	logic cpuRead;
	paletteEntry_u cpuRdData;
	logic bank;
	logic shadow;
	paletteEntry_u pixelEntry;

	// Host side
	paletteBus #(.INDEX_W(INDEX_W)) bus0 (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.cpuIndex(cpuIndex), .cpuWrData(cpuWrData), .cpuByteEn(cpuByteEn),
		.cpuWrite(cpuWrite), .cpuRead(cpuRead), .cpuRdData(cpuRdData),
		.bank(bank), .shadow(shadow)
	);

	// Palette memory
	paletteRam #(.INDEX_W(INDEX_W)) ram0 (
		.CLK_24M(CLK_24M), .bank(bank),
		.cpuIndex(cpuIndex), .cpuWrData(cpuWrData), .cpuByteEn(cpuByteEn),
		.cpuWrite(cpuWrite), .cpuRead(cpuRead), .cpuRdData(cpuRdData),
		.pixelIndex(pixelIndex), .pixelEntry(pixelEntry)
	);

	// Video side
	colorConvert #(.INDEX_W(INDEX_W)) conv0 (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.pixelValid(pixelValid), .pixelEntry(pixelEntry), .shadow(shadow),
		.red(red), .green(green), .blue(blue), .rgbValid(rgbValid)
	);

endmodule

`default_nettype wire

//--- tests/tbClockGen.sv
// Testbench clock and power-on reset source; 8 ns period, reset low for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
	parameter int HALF_PERIOD_NS = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic CLK_24M,
	output logic nRESET
);

	initial begin
		CLK_24M = 1'b0;
		forever #(HALF_PERIOD_NS) CLK_24M = ~CLK_24M;
	end

	// Release on a falling edge, away from the DUT sampling edge
	initial begin
		nRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_24M);
		@(negedge CLK_24M);
		nRESET = 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/neoPalette_assert.sv
// Concurrent checks on AXI response hold, pixel latency and reset state; bound into bus and converter
`timescale 1ns/1ps
`default_nettype none

module neoPaletteAssert (
	input wire logic CLK_24M,
	input wire logic nRESET,
	input wire logic awready,
	input wire logic wready,
	input wire logic arready,
	input wire logic bvalid,
	input wire logic bready,
	input wire logic [1:0] bresp,
	input wire logic rvalid,
	input wire logic rready,
	input wire logic [31:0] rdata,
	input wire logic [1:0] rresp,
	input wire logic pixelValid,
	input wire logic rgbValid
);

	// ======================================================================
	// Response channels hold until taken
	// ======================================================================

	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response changed before bready");

	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read response changed before rready");

	// ======================================================================
	// Pixel pipeline and reset state
	// ======================================================================

	// Fixed two-cycle latency, no stalls on the video side
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		rgbValid == $past(pixelValid, 2))
		else $error("rgbValid does not follow pixelValid by two cycles");

	assert property (@(posedge CLK_24M)
		!nRESET |-> !awready && !wready && !arready && !bvalid && !rvalid && !rgbValid)
		else $error("handshake output high during reset");

endmodule

// Bus instance, pixel side tied off
bind paletteBus neoPaletteAssert busChecks0 (
	.CLK_24M(CLK_24M), .nRESET(nRESET),
	.awready(awready), .wready(wready), .arready(arready),
	.bvalid(bvalid), .bready(bready), .bresp(bresp),
	.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
	.pixelValid(1'b0), .rgbValid(1'b0)
);

// Converter instance, bus side tied off
bind colorConvert neoPaletteAssert convChecks0 (
	.CLK_24M(CLK_24M), .nRESET(nRESET),
	.awready(1'b0), .wready(1'b0), .arready(1'b0),
	.bvalid(1'b0), .bready(1'b0), .bresp(2'b00),
	.rvalid(1'b0), .rready(1'b0), .rdata(32'd0), .rresp(2'b00),
	.pixelValid(pixelValid), .rgbValid(rgbValid)
);

`default_nettype wire

//--- tests/tbNeoPalette.sv
// Directed testbench for the palette block; drives AXI4-Lite and the pixel stream, checks RGB
`timescale 1ns/1ps
`default_nettype none

module tbNeoPalette import paletteDefs::*; ();

	localparam int INDEX_W = PAL_INDEX_W;
	// Limit far above the roughly thousand cycles that the tests take
	localparam int TIMEOUT_CYCLES = 20000;

	logic CLK_24M;
	logic nRESET;
	logic [15:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [15:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [INDEX_W-1:0] pixelIndex;
	logic pixelValid;
	logic [COLOR_W-1:0] red;
	logic [COLOR_W-1:0] green;
	logic [COLOR_W-1:0] blue;
	logic rgbValid;

	// Expected RAM contents with the bank bit above the index
	logic [15:0] model [0:2*(2**INDEX_W)-1];
	logic modelBank;
	logic modelShadow;
	logic [INDEX_W-1:0] pixelList [$];
	logic [23:0] expQ [$];
	integer seed;
	int errCount = 0;
	int checkCount = 0;
	int cycles = 0;

	tbClockGen #(.HALF_PERIOD_NS(4), .RESET_CYCLES(4)) clk0 (
		.CLK_24M(CLK_24M), .nRESET(nRESET)
	);

	neoPaletteTop #(.INDEX_W(INDEX_W)) dut0 (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.pixelIndex(pixelIndex), .pixelValid(pixelValid),
		.red(red), .green(green), .blue(blue), .rgbValid(rgbValid)
	);

	// ======================================================================
	// Reference model and helpers
	// ======================================================================

	function automatic logic [31:0] randWord();
		randWord = $random(seed);
	endfunction

	// 4-bit field and shared lsb to 6 bits, darken, widen to 8, optional halving
	function automatic logic [7:0] refChannel(input logic [3:0] field, input logic lsb,
		input logic dark, input logic half);
		int level;
		int wide;
		level = 4 * int'(field) + 2 * int'(lsb) + int'(field[3]);
		if (dark) level = (level > 0) ? level - 1 : 0;
		// Bits 4 and 3 of the 6-bit level fill the low end
		wide = 4 * level + (level / 8) % 4;
		if (half) wide = wide / 2;
		refChannel = 8'(wide);
	endfunction

	function automatic logic [23:0] expectedRgb(input logic [15:0] value, input logic half);
		paletteEntry_u e;
		e.raw = value;
		expectedRgb = {refChannel(e.color.red, e.color.rLsb, e.color.dark, half),
			refChannel(e.color.green, e.color.gLsb, e.color.dark, half),
			refChannel(e.color.blue, e.color.bLsb, e.color.dark, half)};
	endfunction

	function automatic logic [15:0] modelEntry(input logic [INDEX_W-1:0] index);
		modelEntry = model[{modelBank, index}];
	endfunction

	task automatic compareWord(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errCount++;
			$display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	// ======================================================================
	// AXI4-Lite master
	// ======================================================================

	// Response is held for holdCycles with ready low, then taken
	task automatic axiWrite(input string testName, input logic [15:0] addr,
		input logic [31:0] data, input logic [3:0] strb, input int holdCycles,
		output logic [1:0] resp);
		@(negedge CLK_24M);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		// Ready seen here means the handshake lands on the next rising edge
		@(negedge CLK_24M);
		while (!awready) @(negedge CLK_24M);
		// Both ready lines pulse together
		compareWord(testName, "wready", 32'd1, 32'(wready));
		@(negedge CLK_24M);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid) @(negedge CLK_24M);
		resp = bresp;
		repeat (holdCycles) begin
			@(negedge CLK_24M);
			compareWord(testName, "bvalid held", 32'd1, 32'(bvalid));
			compareWord(testName, "bresp held", 32'(resp), 32'(bresp));
		end
		bready = 1'b1;
		@(negedge CLK_24M);
		bready = 1'b0;
	endtask

	task automatic axiRead(input string testName, input logic [15:0] addr,
		input int holdCycles, output logic [31:0] data, output logic [1:0] resp);
		@(negedge CLK_24M);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge CLK_24M);
		while (!arready) @(negedge CLK_24M);
		@(negedge CLK_24M);
		arvalid = 1'b0;
		while (!rvalid) @(negedge CLK_24M);
		data = rdata;
		resp = rresp;
		repeat (holdCycles) begin
			@(negedge CLK_24M);
			compareWord(testName, "rvalid held", 32'd1, 32'(rvalid));
			compareWord(testName, "rdata held", data, rdata);
		end
		rready = 1'b1;
		@(negedge CLK_24M);
		rready = 1'b0;
	endtask

	task automatic writeEntry(input string testName, input logic [INDEX_W-1:0] index,
		input logic [15:0] value, input logic [3:0] strb);
		logic [1:0] resp;
		axiWrite(testName, 16'({index, 2'b00}), {16'hFFFF, value}, strb, 0, resp);
		compareWord(testName, "write resp", 32'(RESP_OKAY), 32'(resp));
		// Byte enables from wstrb bits 1 and 0
		if (strb[0]) model[{modelBank, index}][7:0] = value[7:0];
		if (strb[1]) model[{modelBank, index}][15:8] = value[15:8];
	endtask

	task automatic readEntry(input string testName, input logic [INDEX_W-1:0] index,
		input logic [15:0] expected);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(testName, 16'({index, 2'b00}), 0, data, resp);
		compareWord(testName, "read resp", 32'(RESP_OKAY), 32'(resp));
		compareWord(testName, "read data", {16'h0000, expected}, data);
	endtask

	task automatic setControl(input string testName, input logic [1:0] value);
		logic [1:0] resp;
		axiWrite(testName, CTRL_ADDR, {30'd0, value}, 4'b0001, 0, resp);
		compareWord(testName, "ctrl write resp", 32'(RESP_OKAY), 32'(resp));
		modelBank = value[CTRL_BANK_BIT];
		modelShadow = value[CTRL_SHADOW_BIT];
	endtask

	task automatic readControl(input string testName, input logic [1:0] expected);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(testName, CTRL_ADDR, 0, data, resp);
		compareWord(testName, "ctrl read resp", 32'(RESP_OKAY), 32'(resp));
		compareWord(testName, "ctrl read data", {30'd0, expected}, data);
	endtask

	// Back-to-back pixels from pixelList with results expected two edges later
	task automatic streamPixels(input string testName);
		int n;
		int k;
		logic [23:0] exp;
		n = pixelList.size();
		for (k = 0; k < n + 2; k++) begin
			@(negedge CLK_24M);
			if (k >= 2) begin
				compareWord(testName, "rgbValid", 32'd1, 32'(rgbValid));
				exp = expQ.pop_front();
				compareWord(testName, "rgb", 32'(exp), 32'({red, green, blue}));
			end else begin
				compareWord(testName, "rgbValid idle", 32'd0, 32'(rgbValid));
			end
			if (k < n) begin
				pixelIndex = pixelList[k];
				pixelValid = 1'b1;
				expQ.push_back(expectedRgb(modelEntry(pixelList[k]), modelShadow));
			end else begin
				pixelValid = 1'b0;
			end
		end
		pixelList.delete();
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic testReadBack();
		logic [INDEX_W-1:0] idx;
		int i;
		for (i = 0; i < 16; i++) begin
			idx = INDEX_W'(randWord());
			writeEntry("readBack", idx, 16'(randWord()), 4'hF);
			readEntry("readBack", idx, modelEntry(idx));
		end
		// One lane at a time on a known word
		idx = INDEX_W'(randWord());
		writeEntry("readBack", idx, 16'hA5C3, 4'hF);
		writeEntry("readBack", idx, 16'h1234, 4'b0001);
		readEntry("readBack", idx, 16'hA534);
		writeEntry("readBack", idx, 16'h7E99, 4'b0010);
		readEntry("readBack", idx, 16'h7E34);
	endtask

	task automatic testPixelColours();
		logic [INDEX_W-1:0] idx;
		int i;
		for (i = 0; i < 24; i++) begin
			idx = INDEX_W'(randWord());
			writeEntry("pixelColours", idx, 16'(randWord()), 4'hF);
			pixelList.push_back(idx);
		end
		streamPixels("pixelColours");
	endtask

	task automatic testDarkShadow();
		logic [INDEX_W-1:0] idx;
		int i;
		// Dark with zero fields and lsbs floors every channel at black
		for (i = 0; i < 4; i++) begin
			idx = INDEX_W'(randWord());
			writeEntry("darkShadow", idx, 16'h8000, 4'hF);
			pixelList.push_back(idx);
		end
		streamPixels("darkShadow");
		setControl("darkShadow", 2'b10);
		for (i = 0; i < 16; i++) begin
			idx = INDEX_W'(randWord());
			writeEntry("darkShadow", idx, 16'(randWord()), 4'hF);
			pixelList.push_back(idx);
		end
		streamPixels("darkShadow");
		setControl("darkShadow", 2'b00);
	endtask

	task automatic testBankSelect();
		logic [INDEX_W-1:0] picks [8];
		int i;
		for (i = 0; i < 8; i++) begin
			picks[i] = INDEX_W'(randWord());
			writeEntry("bankSelect", picks[i], 16'(randWord()), 4'hF);
		end
		setControl("bankSelect", 2'b01);
		readControl("bankSelect", 2'b01);
		for (i = 0; i < 8; i++) begin
			writeEntry("bankSelect", picks[i], 16'(randWord()), 4'hF);
			pixelList.push_back(picks[i]);
		end
		streamPixels("bankSelect");
		for (i = 0; i < 8; i++) readEntry("bankSelect", picks[i], modelEntry(picks[i]));
		setControl("bankSelect", 2'b11);
		readControl("bankSelect", 2'b11);
		setControl("bankSelect", 2'b00);
		readControl("bankSelect", 2'b00);
		// Bank 0 must still hold its own data
		for (i = 0; i < 8; i++) begin
			readEntry("bankSelect", picks[i], modelEntry(picks[i]));
			pixelList.push_back(picks[i]);
		end
		streamPixels("bankSelect");
	endtask

	task automatic testBusErrors();
		logic [31:0] data;
		logic [1:0] resp;
		// Entries that the out-of-range addresses alias onto
		writeEntry("busErrors", 12'h000, 16'h1357, 4'hF);
		writeEntry("busErrors", 12'h001, 16'h2468, 4'hF);
		writeEntry("busErrors", 12'hFFC, 16'h9ABC, 4'hF);
		axiWrite("busErrors", 16'h4004, 32'h0000_FFFF, 4'hF, 0, resp);
		compareWord("busErrors", "write 4004 resp", 32'(RESP_SLVERR), 32'(resp));
		axiWrite("busErrors", 16'hFFF0, 32'h0000_FFFF, 4'hF, 0, resp);
		compareWord("busErrors", "write FFF0 resp", 32'(RESP_SLVERR), 32'(resp));
		axiWrite("busErrors", 16'h8000, 32'h0000_FFFF, 4'hF, 0, resp);
		compareWord("busErrors", "write 8000 resp", 32'(RESP_SLVERR), 32'(resp));
		axiRead("busErrors", 16'h4008, 0, data, resp);
		compareWord("busErrors", "read 4008 resp", 32'(RESP_SLVERR), 32'(resp));
		readEntry("busErrors", 12'h000, 16'h1357);
		readEntry("busErrors", 12'h001, 16'h2468);
		readEntry("busErrors", 12'hFFC, 16'h9ABC);
		readControl("busErrors", 2'b00);
		// Stalled responses stay valid and stable
		axiWrite("busErrors", 16'h0008, 32'h0000_4321, 4'hF, 5, resp);
		compareWord("busErrors", "stalled write resp", 32'(RESP_OKAY), 32'(resp));
		axiRead("busErrors", 16'h0008, 5, data, resp);
		compareWord("busErrors", "stalled read resp", 32'(RESP_OKAY), 32'(resp));
		compareWord("busErrors", "stalled read data", 32'h0000_4321, data);
	endtask

	// ======================================================================
	// Run control
	// ======================================================================

	always @(posedge CLK_24M) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		pixelIndex = '0;
		pixelValid = 1'b0;
		seed = 32'h26ac_0edf;
		modelBank = 1'b0;
		modelShadow = 1'b0;
		@(posedge nRESET);
		testReadBack();
		testPixelColours();
		testDarkShadow();
		testBankSelect();
		testBusErrors();
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- neoPalette.f
hdl/paletteDefs.sv
hdl/paletteBus.sv
hdl/paletteRam.sv
hdl/colorConvert.sv
hdl/neoPaletteTop.sv
tests/tbClockGen.sv
tests/neoPalette_assert.sv
tests/tbNeoPalette.sv

//--- Makefile
# Verilator build and run of the palette block testbench
TOP = tbNeoPalette

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f neoPalette.f -Mdir obj_dir

# Assertion stops end the run early, so a missing pass line also counts as failure
run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "sim failed" sim.log; then echo "FAIL: see sim.log"; exit 1; fi
	@grep -q "sim passed" sim.log || { echo "FAIL: run ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log
